// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := dws_tb
FILELIST  := list.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: list.f
+incdir+logic
logic/dws_pkg.sv
logic/dws_cmd_if.sv
logic/dws_spill_reg.sv
logic/dws_ar_planner.sv
logic/dws_r_assembler.sv
logic/dws_top.sv
sim/dws_sva.sv
sim/dws_tb.sv

// File: logic/dws_ar_planner.sv
`timescale 1ns/100ps
`include "dws_cfg.svh"

module dws_ar_planner (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          ar_valid_i,
  output logic          ar_ready_o,
  input  dws_pkg::ar_t  ar_i,
  output logic          nar_valid_o,
  input  logic          nar_ready_i,
  output dws_pkg::ar_t  nar_o,
  dws_cmd_if.issuer     cmd
);

  localparam int narrow_bytes = 1 << `DWS_NARROW_SIZE;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } state_e;

  state_e             state_q;
  logic               req_q;
  dws_pkg::ar_t       nar_q;
  dws_pkg::rd_cmd_t   cmd_q;

  logic               accept;
  logic               err;
  logic               downsize;
  dws_pkg::addr_t     aligned_start;
  dws_pkg::addr_t     last_byte;
  dws_pkg::addr_t     first_word;
  dws_pkg::addr_t     end_word;
  dws_pkg::addr_t     word_span;
  logic [7:0]         nlen;

  // No new read until the previous handshake has fully closed
  assign ar_ready_o  = (state_q == ST_IDLE) && !cmd.ack;
  assign accept      = ar_valid_i && ar_ready_o;
  assign nar_valid_o = (state_q == ST_ISSUE);
  assign nar_o       = nar_q;
  assign cmd.req     = req_q;
  assign cmd.cmd     = cmd_q;

  // Narrow words touched by the whole burst
  always_comb begin
    aligned_start = ar_i.addr & ~((dws_pkg::addr_t'(1) << ar_i.size) - 1);
    last_byte     = aligned_start + (dws_pkg::addr_t'(ar_i.len) << ar_i.size)
                    + (dws_pkg::addr_t'(1) << ar_i.size) - 1;
    first_word    = ar_i.addr & ~dws_pkg::addr_t'(narrow_bytes - 1);
    end_word      = (last_byte & ~dws_pkg::addr_t'(narrow_bytes - 1)) + narrow_bytes;
    word_span     = ((end_word - first_word) >> `DWS_NARROW_SIZE) - 1;
    nlen          = word_span[7:0];
  end

  // Burst classification
  always_comb begin
    err      = 1'b0;
    downsize = 1'b0;
    case (ar_i.burst)
      dws_pkg::BURST_INCR: begin
        if (ar_i.size > 3'(`DWS_WIDE_SIZE)) begin
          err = 1'b1;
        end else if (ar_i.modifiable) begin
          downsize = 1'b1;
        end else if (ar_i.size > 3'(`DWS_NARROW_SIZE)) begin
          err = 1'b1;
        end
      end
      // Only single narrow beats can pass
      dws_pkg::BURST_WRAP, dws_pkg::BURST_FIXED: begin
        err = (ar_i.len != 8'd0) || (ar_i.size > 3'(`DWS_NARROW_SIZE));
      end
      default: begin
        err = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            req_q   <= 1'b1;
            // Error reads never reach the narrow port
            state_q <= err ? ST_WAIT : ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (nar_ready_i) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (cmd.ack) begin
            req_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      nar_q <= ar_i;
      if (downsize) begin
        nar_q.len  <= nlen;
        nar_q.size <= 3'(`DWS_NARROW_SIZE);
      end
      cmd_q.id   <= ar_i.id;
      cmd_q.addr <= ar_i.addr;
      cmd_q.size <= ar_i.size;
      cmd_q.len  <= ar_i.len;
      cmd_q.nlen <= downsize ? nlen : ar_i.len;
      cmd_q.err  <= err;
    end
  end

endmodule

// File: logic/dws_cfg.svh
`ifndef DWS_CFG_SVH
`define DWS_CFG_SVH

// Address and ID widths
`define DWS_ADDR_W 32
`define DWS_ID_W 4

// Data widths of the wide and the narrow port
`define DWS_WIDE_W 64
`define DWS_NARROW_W 32

// Log2 of bytes per beat on each port
`define DWS_WIDE_SIZE 3
`define DWS_NARROW_SIZE 2

`endif

// File: logic/dws_cmd_if.sv
`timescale 1ns/100ps

interface dws_cmd_if;

  // Four-phase req/ack, cmd held while req is high
  logic              req;
  logic              ack;
  dws_pkg::rd_cmd_t  cmd;

  // AR side posts the command
  modport issuer (
    output req,
    output cmd,
    input  ack
  );

  // R side completes it
  modport executor (
    input  req,
    input  cmd,
    output ack
  );

endinterface

// File: logic/dws_pkg.sv
`include "dws_cfg.svh"

package dws_pkg;

  typedef logic [`DWS_ADDR_W-1:0] addr_t;
  typedef logic [`DWS_ID_W-1:0] id_t;

  // AXI burst encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Responses seen by the converter
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Read address channel, same layout on both ports
  typedef struct packed {
    id_t         id;
    addr_t       addr;
    logic [7:0]  len;
    logic [2:0]  size;
    burst_e      burst;
    logic        modifiable;
  } ar_t;

  // Narrow read data channel
  typedef struct packed {
    id_t                       id;
    logic [`DWS_NARROW_W-1:0]  data;
    resp_e                     resp;
    logic                      last;
  } narrow_r_t;

  // One read as seen by the R side
  typedef struct packed {
    id_t         id;
    addr_t       addr;
    logic [2:0]  size;
    logic [7:0]  len;
    logic [7:0]  nlen;
    logic        err;
  } rd_cmd_t;

endpackage

// File: logic/dws_r_assembler.sv
`timescale 1ns/100ps
`include "dws_cfg.svh"

module dws_r_assembler (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  dws_cmd_if.executor               cmd,
  input  logic                      nr_valid_i,
  output logic                      nr_ready_o,
  input  dws_pkg::narrow_r_t        nr_i,
  output logic                      r_valid_o,
  input  logic                      r_ready_i,
  output logic [`DWS_ID_W-1:0]      r_id_o,
  output logic [`DWS_WIDE_W-1:0]    r_data_o,
  output dws_pkg::resp_e            r_resp_o,
  output logic                      r_last_o
);

  localparam int narrow_bytes = 1 << `DWS_NARROW_SIZE;
  localparam int wide_bytes   = 1 << `DWS_WIDE_SIZE;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_ACK
  } state_e;

  state_e                     state_q;
  logic                       ack_q;
  logic                       fresh_q;
  logic [7:0]                 beat_q;
  dws_pkg::addr_t             ptr_q;
  logic                       r_valid_q;
  logic [`DWS_WIDE_W-1:0]     r_data_q;
  dws_pkg::resp_e             r_resp_q;
  logic                       r_last_q;

  logic                       can_load;
  logic                       err_load;
  logic                       take;
  logic                       final_beat;
  logic                       one_to_one;
  logic                       spans;
  logic                       pop;
  dws_pkg::addr_t             blk_mask;
  dws_pkg::addr_t             blk_end;
  dws_pkg::addr_t             rem_blk;
  dws_pkg::addr_t             rem_word;
  dws_pkg::addr_t             chunk;
  logic [`DWS_WIDE_SIZE-1:0]  lo;
  logic [`DWS_WIDE_W-1:0]     data_d;
  dws_pkg::resp_e             resp_d;

  assign cmd.ack   = ack_q;
  assign r_valid_o = r_valid_q;
  assign r_id_o    = cmd.cmd.id;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;
  assign r_last_o  = r_last_q;

  // Every original beat has its own narrow beat
  assign one_to_one = (cmd.cmd.nlen == cmd.cmd.len);
  assign final_beat = (beat_q == cmd.cmd.len);

  // Output slot free or draining, and the last beat not yet loaded
  assign can_load = (state_q == ST_RUN) && !(r_valid_q && r_last_q)
                    && (!r_valid_q || r_ready_i);
  assign err_load = can_load && cmd.cmd.err;
  assign take     = can_load && !cmd.cmd.err && nr_valid_i;
  assign nr_ready_o = take && pop;

  // Bytes of the current beat that sit in the current narrow word
  always_comb begin
    blk_mask = (dws_pkg::addr_t'(1) << cmd.cmd.size) - 1;
    blk_end  = (ptr_q & ~blk_mask) + blk_mask + 1;
    rem_blk  = blk_end - ptr_q;
    rem_word = dws_pkg::addr_t'(narrow_bytes)
               - (ptr_q & dws_pkg::addr_t'(narrow_bytes - 1));
    spans    = rem_blk > rem_word;
    chunk    = spans ? rem_word : rem_blk;
    lo       = ptr_q[`DWS_WIDE_SIZE-1:0];
    // Word fully used, or nothing later needs it
    pop      = spans || (rem_blk == rem_word) || final_beat || one_to_one;
  end

  // Byte at address A moves from narrow lane A mod 4 to wide lane A mod 8
  always_comb begin
    data_d = fresh_q ? '0 : r_data_q;
    for (int b = 0; b < wide_bytes; b++) begin
      if (b >= int'(lo) && b < int'(lo) + int'(chunk)) begin
        data_d[8*b +: 8] = nr_i.data[8*(b % narrow_bytes) +: 8];
      end
    end
    if (fresh_q || nr_i.resp > r_resp_q) begin
      resp_d = nr_i.resp;
    end else begin
      resp_d = r_resp_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      ack_q     <= 1'b0;
      fresh_q   <= 1'b1;
      beat_q    <= 8'd0;
      ptr_q     <= '0;
      r_valid_q <= 1'b0;
    end else begin
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (cmd.req) begin
            state_q <= ST_RUN;
            ptr_q   <= cmd.cmd.addr;
            beat_q  <= 8'd0;
            fresh_q <= 1'b1;
          end
        end
        ST_RUN: begin
          if (r_valid_q && r_ready_i && r_last_q) begin
            state_q <= ST_ACK;
            ack_q   <= 1'b1;
          end
          if (err_load) begin
            r_valid_q <= 1'b1;
            beat_q    <= beat_q + 8'd1;
          end else if (take) begin
            if (spans) begin
              // Rest of this wide beat is in the next narrow word
              ptr_q   <= ptr_q + rem_word;
              fresh_q <= 1'b0;
            end else begin
              ptr_q     <= blk_end;
              fresh_q   <= 1'b1;
              r_valid_q <= 1'b1;
              beat_q    <= beat_q + 8'd1;
            end
          end
        end
        ST_ACK: begin
          if (!cmd.req) begin
            ack_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_load) begin
      r_data_q <= '0;
      r_resp_q <= dws_pkg::RESP_SLVERR;
      r_last_q <= final_beat;
    end else if (take) begin
      r_data_q <= data_d;
      r_resp_q <= resp_d;
      r_last_q <= final_beat;
    end
  end

endmodule

// File: logic/dws_spill_reg.sv
`timescale 1ns/100ps

module dws_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  payload_t  in_data_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output payload_t  out_data_o
);

  logic      full_q;
  payload_t  data_q;

  // Room when empty or when the held entry leaves this cycle
  assign in_ready_o  = !full_q || out_ready_i;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

endmodule

// File: logic/dws_top.sv
`timescale 1ns/100ps
`include "dws_cfg.svh"

module dws_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Wide AR
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  logic [`DWS_ID_W-1:0]       ar_id_i,
  input  logic [`DWS_ADDR_W-1:0]     ar_addr_i,
  input  logic [7:0]                 ar_len_i,
  input  logic [2:0]                 ar_size_i,
  input  logic [1:0]                 ar_burst_i,
  input  logic                       ar_modifiable_i,
  // Wide R
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output logic [`DWS_ID_W-1:0]       r_id_o,
  output logic [`DWS_WIDE_W-1:0]     r_data_o,
  output logic [1:0]                 r_resp_o,
  output logic                       r_last_o,
  // Narrow AR
  output logic                       nar_valid_o,
  input  logic                       nar_ready_i,
  output logic [`DWS_ID_W-1:0]       nar_id_o,
  output logic [`DWS_ADDR_W-1:0]     nar_addr_o,
  output logic [7:0]                 nar_len_o,
  output logic [2:0]                 nar_size_o,
  output logic [1:0]                 nar_burst_o,
  // Narrow R
  input  logic                       nr_valid_i,
  output logic                       nr_ready_o,
  input  logic [`DWS_ID_W-1:0]       nr_id_i,
  input  logic [`DWS_NARROW_W-1:0]   nr_data_i,
  input  logic [1:0]                 nr_resp_i,
  input  logic                       nr_last_i
);

  dws_pkg::ar_t        ar;
  dws_pkg::ar_t        nar_req;
  dws_pkg::ar_t        nar;
  dws_pkg::narrow_r_t  nr;
  dws_pkg::narrow_r_t  nr_q;
  dws_pkg::resp_e      r_resp;
  logic                nar_req_valid;
  logic                nar_req_ready;
  logic                nr_q_valid;
  logic                nr_q_ready;

  dws_cmd_if rd_cmd ();

  assign ar.id         = ar_id_i;
  assign ar.addr       = ar_addr_i;
  assign ar.len        = ar_len_i;
  assign ar.size       = ar_size_i;
  assign ar.burst      = dws_pkg::burst_e'(ar_burst_i);
  assign ar.modifiable = ar_modifiable_i;

  assign nr.id   = nr_id_i;
  assign nr.data = nr_data_i;
  assign nr.resp = dws_pkg::resp_e'(nr_resp_i);
  assign nr.last = nr_last_i;

  dws_ar_planner i_planner (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_i        (ar),
    .nar_valid_o (nar_req_valid),
    .nar_ready_i (nar_req_ready),
    .nar_o       (nar_req),
    .cmd         (rd_cmd)
  );

  // Narrow AR register
  dws_spill_reg #(
    .payload_t (dws_pkg::ar_t)
  ) i_nar_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (nar_req_valid),
    .in_ready_o  (nar_req_ready),
    .in_data_i   (nar_req),
    .out_valid_o (nar_valid_o),
    .out_ready_i (nar_ready_i),
    .out_data_o  (nar)
  );

  assign nar_id_o    = nar.id;
  assign nar_addr_o  = nar.addr;
  assign nar_len_o   = nar.len;
  assign nar_size_o  = nar.size;
  assign nar_burst_o = nar.burst;

  // Narrow R register
  dws_spill_reg #(
    .payload_t (dws_pkg::narrow_r_t)
  ) i_nr_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (nr_valid_i),
    .in_ready_o  (nr_ready_o),
    .in_data_i   (nr),
    .out_valid_o (nr_q_valid),
    .out_ready_i (nr_q_ready),
    .out_data_o  (nr_q)
  );

  dws_r_assembler i_assembler (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd        (rd_cmd),
    .nr_valid_i (nr_q_valid),
    .nr_ready_o (nr_q_ready),
    .nr_i       (nr_q),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_id_o     (r_id_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp),
    .r_last_o   (r_last_o)
  );

  assign r_resp_o = r_resp;

endmodule

// File: sim/dws_sva.sv
`timescale 1ns/100ps

module dws_sva (
  input logic         clk_i,
  input logic         rst_ni,
  input logic         r_valid_o,
  input logic         r_ready_i,
  input logic [3:0]   r_id_o,
  input logic [63:0]  r_data_o,
  input logic [1:0]   r_resp_o,
  input logic         r_last_o,
  input logic         nar_valid_o,
  input logic         nar_ready_i,
  input logic [3:0]   nar_id_o,
  input logic [31:0]  nar_addr_o,
  input logic [7:0]   nar_len_o,
  input logic [2:0]   nar_size_o,
  input logic [1:0]   nar_burst_o,
  input logic         err_read_i,
  input logic         req_i
);

  // Valid held until the transfer
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o)
    else $error("wide R valid dropped without ready");

  nar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nar_valid_o && !nar_ready_i |=> nar_valid_o)
    else $error("narrow AR valid dropped without ready");

  // Payload stable while stalled
  r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> $stable({r_id_o, r_data_o, r_resp_o, r_last_o}))
    else $error("wide R payload changed while stalled");

  nar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nar_valid_o && !nar_ready_i |=>
      $stable({nar_id_o, nar_addr_o, nar_len_o, nar_size_o, nar_burst_o}))
    else $error("narrow AR payload changed while stalled");

  // Unsupported bursts stay local
  no_err_nar: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && err_read_i |-> !nar_valid_o)
    else $error("narrow AR seen for an unsupported burst");

endmodule

bind dws_top dws_sva u_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .r_valid_o   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .r_id_o      (r_id_o),
  .r_data_o    (r_data_o),
  .r_resp_o    (r_resp_o),
  .r_last_o    (r_last_o),
  .nar_valid_o (nar_valid_o),
  .nar_ready_i (nar_ready_i),
  .nar_id_o    (nar_id_o),
  .nar_addr_o  (nar_addr_o),
  .nar_len_o   (nar_len_o),
  .nar_size_o  (nar_size_o),
  .nar_burst_o (nar_burst_o),
  .err_read_i  (i_planner.cmd_q.err),
  .req_i       (i_planner.req_q)
);

// File: sim/dws_tb.sv
`timescale 1ns/100ps

module dws_tb;

  localparam int num_reads = 60;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         ar_valid_i, ar_modifiable_i, r_ready_i, nar_ready_i;
  logic [3:0]   ar_id_i, nr_id_i;
  logic [31:0]  ar_addr_i, nr_data_i;
  logic [7:0]   ar_len_i;
  logic [2:0]   ar_size_i;
  logic [1:0]   ar_burst_i, nr_resp_i;
  logic         nr_valid_i, nr_last_i;
  logic         ar_ready_o, r_valid_o, r_last_o, nar_valid_o, nr_ready_o;
  logic [3:0]   r_id_o, nar_id_o;
  logic [63:0]  r_data_o;
  logic [1:0]   r_resp_o, nar_burst_o;
  logic [31:0]  nar_addr_o;
  logic [7:0]   nar_len_o;
  logic [2:0]   nar_size_o;

  integer       seed;
  int           errors;
  int           cycles;
  int           limit;
  // Current read and its expected results
  logic         err, down;
  logic [7:0]   nlen;
  logic [63:0]  exp_data [0:255];
  logic [1:0]   exp_resp [0:255];
  bit           nerr [0:255];

  always #20 clk_i = ~clk_i;

  dws_top u_dut (.*);

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Random AR and the classification rules
  task automatic pick_read();
    int kind;
    kind = $random(seed) & 3;
    ar_burst_i      = (kind < 2) ? 2'b01 : ((kind == 2) ? 2'b10 : 2'b00);
    ar_id_i         = 4'($random(seed));
    ar_addr_i       = $random(seed) & 32'h0000_ffff;
    ar_size_i       = 3'($random(seed) & 3);
    ar_modifiable_i = 1'($random(seed));
    ar_len_i        = 8'($random(seed) & 15);
    if (ar_burst_i != 2'b01 && ($random(seed) & 1)) ar_len_i = 8'd0;
    down = (ar_burst_i == 2'b01) && ar_modifiable_i;
    if (ar_burst_i == 2'b01) err = !ar_modifiable_i && ar_size_i > 2;
    else err = (ar_len_i != 0) || (ar_size_i > 2);
  endtask

  task automatic build_expected();
    logic [31:0] bs, a0, blk, idx, a;
    logic        bad;
    bs = 32'd1 << ar_size_i;
    // Words between narrow-aligned start and narrow-aligned last byte
    a = (ar_addr_i & ~(bs - 1)) + ((32'(ar_len_i) + 1) << ar_size_i) - 1;
    nlen = down ? 8'(((a >> 2) - (ar_addr_i >> 2))) : ar_len_i;
    for (int k = 0; k <= nlen; k++) nerr[k] = (($random(seed) & 7) == 0);
    for (int i = 0; i <= ar_len_i; i++) begin
      a0  = (i == 0) ? ar_addr_i : (ar_addr_i & ~(bs - 1)) + (32'(i) << ar_size_i);
      blk = (a0 & ~(bs - 1)) + bs;
      exp_data[i] = '0;
      bad = 1'b0;
      for (a = a0; a < blk; a++) begin
        exp_data[i][8*(a%8) +: 8] = a[7:0] ^ 8'h5a;
        idx = down ? ((a >> 2) - (ar_addr_i >> 2)) : 32'(i);
        if (nerr[idx]) bad = 1'b1;
      end
      exp_resp[i] = bad ? 2'b10 : 2'b00;
      if (err) begin
        exp_data[i] = '0;
        exp_resp[i] = 2'b10;
      end
    end
  endtask

  // Narrow slave beat k with every lane carrying its own byte
  task automatic drive_narrow(input int k);
    logic [31:0] bs, word;
    bs = 32'd1 << ar_size_i;
    if (down) word = (ar_addr_i & ~32'd3) + 32'(4 * k);
    else word = ((ar_addr_i & ~(bs - 1)) + (32'(k) << ar_size_i)) & ~32'd3;
    for (int j = 0; j < 4; j++) nr_data_i[8*j +: 8] = 8'(word + j) ^ 8'h5a;
    nr_id_i    = ar_id_i;
    nr_resp_i  = nerr[k] ? 2'b10 : 2'b00;
    nr_last_i  = (k == nlen);
    nr_valid_i = 1'b1;
  endtask

  task automatic run_read();
    bit ar_done, nar_seen, nr_take;
    int rcnt, nbeat;
    ar_done = 0;
    nar_seen = 0;
    nr_take = 0;
    rcnt = 0;
    nbeat = 0;
    while (rcnt <= ar_len_i) begin
      @(negedge clk_i);
      cycles++;
      ar_valid_i  = !ar_done;
      nar_ready_i = 1'($random(seed));
      r_ready_i   = ($random(seed) & 3) != 0;
      if (nr_take) begin
        nr_valid_i = 1'b0;
        nr_take = 0;
      end
      if (!nr_valid_i && nar_seen && nbeat <= nlen && ($random(seed) & 3) != 0)
        drive_narrow(nbeat);
      #1;
      if (ar_valid_i && ar_ready_o) ar_done = 1;
      if (nar_valid_o && nar_ready_i) begin
        if (err) begin
          $display("Narrow AR issued for an unsupported burst");
          errors++;
        end
        compare("nar_id", 64'(ar_id_i), 64'(nar_id_o));
        compare("nar_addr", 64'(ar_addr_i), 64'(nar_addr_o));
        compare("nar_len", 64'(nlen), 64'(nar_len_o));
        compare("nar_size", down ? 64'd2 : 64'(ar_size_i), 64'(nar_size_o));
        compare("nar_burst", 64'(ar_burst_i), 64'(nar_burst_o));
        nar_seen = 1;
      end
      if (nr_valid_i && nr_ready_o) begin
        nbeat++;
        nr_take = 1;
      end
      if (r_valid_o && r_ready_i) begin
        compare("r_id", 64'(ar_id_i), 64'(r_id_o));
        compare("r_data", exp_data[rcnt], r_data_o);
        compare("r_resp", 64'(exp_resp[rcnt]), 64'(r_resp_o));
        compare("r_last", 64'(rcnt == ar_len_i), 64'(r_last_o));
        rcnt++;
      end
    end
    if (!err && !nar_seen) begin
      $display("No narrow AR seen for a supported burst");
      errors++;
    end
    // Every narrow beat must be taken before the last wide beat
    if (!err) begin
      compare("narrow_beats", 64'(nlen) + 64'd1, 64'(nbeat));
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    nr_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    #1;
    compare("r_valid_after_last", 64'd0, 64'(r_valid_o));
  endtask

  // Cycle limit for a hung read
  initial begin
    wait (cycles > limit);
    $display("Timeout: read did not complete after %0d cycles", cycles);
    $display("errors: %0d", errors + 1);
    $display("test failed");
    $finish;
  end

  initial begin
    seed   = 32'h56f1_0795;
    errors = 0;
    cycles = 0;
    limit  = 200 * num_reads + 100;
    rst_ni = 1'b0;
    {ar_valid_i, ar_modifiable_i, r_ready_i, nar_ready_i} = '0;
    {ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i} = '0;
    {nr_valid_i, nr_id_i, nr_data_i, nr_resp_i, nr_last_i} = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    compare("reset_ar_ready", 64'd1, 64'(ar_ready_o));
    compare("reset_r_valid", 64'd0, 64'(r_valid_o));
    compare("reset_nar_valid", 64'd0, 64'(nar_valid_o));
    for (int n = 0; n < num_reads; n++) begin
      pick_read();
      build_expected();
      run_read();
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
